//--- Makefile
SRCS := $(shell grep '\.sv$$' sources.f) rtl/pinmux_macros.svh

obj_dir/Vpinmux_tb: sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module pinmux_tb -o Vpinmux_tb

run: obj_dir/Vpinmux_tb
	./obj_dir/Vpinmux_tb | tee sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- rtl/pad_wrapper.sv
`timescale 1ns/100ps

module pad_wrapper (
  // Bidirectional pad wire
  inout wire                    inout_io,
  // Core side output value and enable
  input  logic                  out_i,
  input  logic                  oe_i,
  // Invert and open-drain controls
  input  pinmux_pkg::pad_attr_t attr_i,
  // Core side input, attributes applied
  output logic                  in_o,
  // Pad wire as seen, for DFT
  output logic                  in_raw_o
);

  logic out_pad;
  logic drive_en;

  // Output polarity is applied before the driver
  assign out_pad = out_i ^ attr_i.invert;

  // Open drain
  // only a low value is actively driven, a high releases the line
  // Push-pull
  // drive whenever the core enables the output
  always_comb begin
    if (attr_i.od_en) begin
      drive_en = oe_i & ~out_pad;
    end else begin
      drive_en = oe_i;
    end
  end

  // Behavioural tristate driver
  assign inout_io = drive_en ? out_pad : 1'bz;

  // Input buffer always samples, no input enable
  assign in_raw_o = inout_io;

  // Undo the inversion so the core sees its own polarity
  assign in_o = in_raw_o ^ attr_i.invert;

endmodule : pad_wrapper

//--- rtl/padring.sv
`timescale 1ns/100ps

`include "pinmux_macros.svh"

module padring #(
  parameter int N_DIO = `PINMUX_N_DIO,
  parameter int N_MIO = `PINMUX_N_MIO
) (
  // Pad wires
  inout wire                              [N_DIO-1:0] dio_pad_io,
  inout wire                              [N_MIO-1:0] mio_pad_io,
  // Dedicated pads, straight from the peripherals
  input  logic                            [N_DIO-1:0] dio_out_i,
  input  logic                            [N_DIO-1:0] dio_oe_i,
  input  pinmux_pkg::pad_attr_t           [N_DIO-1:0] dio_attr_i,
  // Muxed pads, driven by the routing matrix
  input  logic                            [N_MIO-1:0] mio_out_i,
  input  logic                            [N_MIO-1:0] mio_oe_i,
  input  pinmux_pkg::pad_attr_t           [N_MIO-1:0] mio_attr_i,
  // Pad inputs back to the core
  output logic                            [N_DIO-1:0] dio_in_o,
  output logic                            [N_MIO-1:0] mio_in_o,
  // Raw pad values for DFT
  output logic                            [N_DIO-1:0] dio_in_raw_o,
  output logic                            [N_MIO-1:0] mio_in_raw_o
);

  // One wrapper per dedicated pad
  for (genvar k = 0; k < N_DIO; k++) begin : gen_dio_pads
    pad_wrapper u_dio_pad (
      .inout_io ( dio_pad_io[k]   ),
      .out_i    ( dio_out_i[k]    ),
      .oe_i     ( dio_oe_i[k]     ),
      .attr_i   ( dio_attr_i[k]   ),
      .in_o     ( dio_in_o[k]     ),
      .in_raw_o ( dio_in_raw_o[k] )
    );
  end

  // One wrapper per muxed pad
  for (genvar k = 0; k < N_MIO; k++) begin : gen_mio_pads
    pad_wrapper u_mio_pad (
      .inout_io ( mio_pad_io[k]   ),
      .out_i    ( mio_out_i[k]    ),
      .oe_i     ( mio_oe_i[k]     ),
      .attr_i   ( mio_attr_i[k]   ),
      .in_o     ( mio_in_o[k]     ),
      .in_raw_o ( mio_in_raw_o[k] )
    );
  end

endmodule : padring

//--- rtl/pinmux_macros.svh
`ifndef PINMUX_MACROS_SVH
`define PINMUX_MACROS_SVH

// Pad counts
`define PINMUX_N_MIO 8
`define PINMUX_N_DIO 2

// Peripheral signal counts on the muxed side
`define PINMUX_N_PERIPH_IN 8
`define PINMUX_N_PERIPH_OUT 8

// Wishbone widths, byte address
`define PINMUX_ADDR_W 8
`define PINMUX_DATA_W 32

// Register array base offsets, one 32-bit word per entry
`define PINMUX_INSEL_BASE 8'h00
`define PINMUX_OUTSEL_BASE 8'h40
`define PINMUX_MIO_ATTR_BASE 8'h80
`define PINMUX_DIO_ATTR_BASE 8'hC0

`endif

//--- rtl/pinmux_matrix.sv
`timescale 1ns/100ps

`include "pinmux_macros.svh"

module pinmux_matrix (
  // Routing selects from the register file
  input  pinmux_pkg::insel_t  [`PINMUX_N_PERIPH_IN-1:0]  insel_i,
  input  pinmux_pkg::outsel_t [`PINMUX_N_MIO-1:0]        outsel_i,
  // Peripheral side
  input  logic                [`PINMUX_N_PERIPH_OUT-1:0] periph_out_i,
  input  logic                [`PINMUX_N_PERIPH_OUT-1:0] periph_oe_i,
  output logic                [`PINMUX_N_PERIPH_IN-1:0]  periph_in_o,
  // Pad side
  input  logic                [`PINMUX_N_MIO-1:0]        mio_in_i,
  output logic                [`PINMUX_N_MIO-1:0]        mio_out_o,
  output logic                [`PINMUX_N_MIO-1:0]        mio_oe_o
);

  import pinmux_pkg::*;

  // Output routing, one mux per MIO pad
  always_comb begin
    for (int j = 0; j < `PINMUX_N_MIO; j++) begin
      // Code 0 and anything out of range drive a constant 0
      mio_out_o[j] = 1'b0;
      mio_oe_o[j] = 1'b1;
      if (outsel_i[j] == outsel_t'(SEL_CONST1)) begin
        mio_out_o[j] = 1'b1;
      end
      // Peripheral source brings its own output enable
      for (int i = 0; i < `PINMUX_N_PERIPH_OUT; i++) begin
        if (outsel_i[j] == outsel_t'(SEL_FIRST + i)) begin
          mio_out_o[j] = periph_out_i[i];
          mio_oe_o[j] = periph_oe_i[i];
        end
      end
    end
  end

  // Input routing, one mux per peripheral input
  always_comb begin
    for (int k = 0; k < `PINMUX_N_PERIPH_IN; k++) begin
      periph_in_o[k] = 1'b0;
      if (insel_i[k] == insel_t'(SEL_CONST1)) begin
        periph_in_o[k] = 1'b1;
      end
      for (int j = 0; j < `PINMUX_N_MIO; j++) begin
        if (insel_i[k] == insel_t'(SEL_FIRST + j)) begin
          periph_in_o[k] = mio_in_i[j];
        end
      end
    end
  end

endmodule : pinmux_matrix

//--- rtl/pinmux_pkg.sv
`include "pinmux_macros.svh"

package pinmux_pkg;

  // Per-pad attributes, shared by DIO and MIO pads
  typedef struct packed {
    logic invert;
    logic od_en;
  } pad_attr_t;

  localparam int unsigned ATTR_W = $bits(pad_attr_t);

  // Select codes 0 and 1 are constants, sources start at code 2
  localparam int unsigned SEL_CONST1 = 1;
  localparam int unsigned SEL_FIRST = 2;

  // Wide enough for the larger of the two source ranges plus the constants
  localparam int unsigned SEL_W =
    $clog2(((`PINMUX_N_MIO > `PINMUX_N_PERIPH_OUT) ?
            `PINMUX_N_MIO : `PINMUX_N_PERIPH_OUT) + SEL_FIRST);

  // Source of one peripheral input
  // 0 const 0, 1 const 1, 2+j MIO pad j
  typedef logic [SEL_W-1:0] insel_t;

  // Source of one MIO pad
  // 0 const 0, 1 const 1, 2+i peripheral output i
  typedef logic [SEL_W-1:0] outsel_t;

endpackage : pinmux_pkg

//--- rtl/pinmux_regs.sv
`timescale 1ns/100ps

`include "pinmux_macros.svh"

module pinmux_regs (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  // Wishbone classic slave
  input  logic                                           wb_cyc_i,
  input  logic                                           wb_stb_i,
  input  logic                                           wb_we_i,
  input  logic                  [`PINMUX_ADDR_W-1:0]     wb_adr_i,
  input  logic                  [`PINMUX_DATA_W-1:0]     wb_dat_i,
  input  logic                  [3:0]                    wb_sel_i,
  output logic                  [`PINMUX_DATA_W-1:0]     wb_dat_o,
  output logic                                           wb_ack_o,
  // Register contents
  output pinmux_pkg::insel_t    [`PINMUX_N_PERIPH_IN-1:0] insel_o,
  output pinmux_pkg::outsel_t   [`PINMUX_N_MIO-1:0]       outsel_o,
  output pinmux_pkg::pad_attr_t [`PINMUX_N_MIO-1:0]       mio_attr_o,
  output pinmux_pkg::pad_attr_t [`PINMUX_N_DIO-1:0]       dio_attr_o
);

  import pinmux_pkg::*;

  localparam logic [7:0] INSEL_BASE = `PINMUX_INSEL_BASE;
  localparam logic [7:0] OUTSEL_BASE = `PINMUX_OUTSEL_BASE;
  localparam logic [7:0] MIO_ATTR_BASE = `PINMUX_MIO_ATTR_BASE;
  localparam logic [7:0] DIO_ATTR_BASE = `PINMUX_DIO_ATTR_BASE;

  insel_t    [`PINMUX_N_PERIPH_IN-1:0] insel_q;
  outsel_t   [`PINMUX_N_MIO-1:0]       outsel_q;
  pad_attr_t [`PINMUX_N_MIO-1:0]       mio_attr_q;
  pad_attr_t [`PINMUX_N_DIO-1:0]       dio_attr_q;

  logic                      ack_q;
  logic                      access;
  logic                      wr_en;
  logic [3:0]                word_idx;
  logic                      hit_insel;
  logic                      hit_outsel;
  logic                      hit_mio_attr;
  logic                      hit_dio_attr;
  logic [`PINMUX_DATA_W-1:0] rdata;

  // New cycle seen, ack not yet given
  assign access = wb_cyc_i & wb_stb_i & ~ack_q;
  // Only the low byte lane carries register bits
  assign wr_en = access & wb_we_i & wb_sel_i[0];

  // Top two address bits pick the array, the next four the entry
  assign word_idx = wb_adr_i[5:2];
  assign hit_insel = (wb_adr_i[7:6] == INSEL_BASE[7:6]);
  assign hit_outsel = (wb_adr_i[7:6] == OUTSEL_BASE[7:6]);
  assign hit_mio_attr = (wb_adr_i[7:6] == MIO_ATTR_BASE[7:6]);
  assign hit_dio_attr = (wb_adr_i[7:6] == DIO_ATTR_BASE[7:6]);

  // Single-cycle ack, one clock after the request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Masked field writes on the edge that raises ack
  // Entries beyond each array's count match no loop index and are dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      insel_q <= '0;
      outsel_q <= '0;
      mio_attr_q <= '0;
      dio_attr_q <= '0;
    end else if (wr_en) begin
      for (int k = 0; k < `PINMUX_N_PERIPH_IN; k++) begin
        if (hit_insel && word_idx == 4'(k)) begin
          insel_q[k] <= wb_dat_i[SEL_W-1:0];
        end
      end
      for (int k = 0; k < `PINMUX_N_MIO; k++) begin
        if (hit_outsel && word_idx == 4'(k)) begin
          outsel_q[k] <= wb_dat_i[SEL_W-1:0];
        end
        if (hit_mio_attr && word_idx == 4'(k)) begin
          mio_attr_q[k] <= wb_dat_i[ATTR_W-1:0];
        end
      end
      for (int k = 0; k < `PINMUX_N_DIO; k++) begin
        if (hit_dio_attr && word_idx == 4'(k)) begin
          dio_attr_q[k] <= wb_dat_i[ATTR_W-1:0];
        end
      end
    end
  end

  // Read mux, fields zero-extended, unmapped words read zero
  // Address is held by the master, so data is stable while ack is high
  always_comb begin
    rdata = '0;
    for (int k = 0; k < `PINMUX_N_PERIPH_IN; k++) begin
      if (hit_insel && word_idx == 4'(k)) begin
        rdata[SEL_W-1:0] = insel_q[k];
      end
    end
    for (int k = 0; k < `PINMUX_N_MIO; k++) begin
      if (hit_outsel && word_idx == 4'(k)) begin
        rdata[SEL_W-1:0] = outsel_q[k];
      end
      if (hit_mio_attr && word_idx == 4'(k)) begin
        rdata[ATTR_W-1:0] = mio_attr_q[k];
      end
    end
    for (int k = 0; k < `PINMUX_N_DIO; k++) begin
      if (hit_dio_attr && word_idx == 4'(k)) begin
        rdata[ATTR_W-1:0] = dio_attr_q[k];
      end
    end
  end

  assign wb_dat_o = rdata;
  assign wb_ack_o = ack_q;

  assign insel_o = insel_q;
  assign outsel_o = outsel_q;
  assign mio_attr_o = mio_attr_q;
  assign dio_attr_o = dio_attr_q;

endmodule : pinmux_regs

//--- rtl/pinmux_top.sv
`timescale 1ns/100ps

`include "pinmux_macros.svh"

module pinmux_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Wishbone classic slave
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [`PINMUX_ADDR_W-1:0]       wb_adr_i,
  input  logic [`PINMUX_DATA_W-1:0]       wb_dat_i,
  input  logic [3:0]                      wb_sel_i,
  output logic [`PINMUX_DATA_W-1:0]       wb_dat_o,
  output logic                            wb_ack_o,
  // Muxed peripheral signals
  input  logic [`PINMUX_N_PERIPH_OUT-1:0] periph_out_i,
  input  logic [`PINMUX_N_PERIPH_OUT-1:0] periph_oe_i,
  output logic [`PINMUX_N_PERIPH_IN-1:0]  periph_in_o,
  // Dedicated peripheral signals
  input  logic [`PINMUX_N_DIO-1:0]        dio_out_i,
  input  logic [`PINMUX_N_DIO-1:0]        dio_oe_i,
  output logic [`PINMUX_N_DIO-1:0]        dio_in_o,
  // Pads
  inout  wire  [`PINMUX_N_MIO-1:0]        mio_pad_io,
  inout  wire  [`PINMUX_N_DIO-1:0]        dio_pad_io,
  // Raw pad values for DFT
  output logic [`PINMUX_N_MIO-1:0]        mio_in_raw_o,
  output logic [`PINMUX_N_DIO-1:0]        dio_in_raw_o
);

  import pinmux_pkg::*;

  insel_t    [`PINMUX_N_PERIPH_IN-1:0] insel;
  outsel_t   [`PINMUX_N_MIO-1:0]       outsel;
  pad_attr_t [`PINMUX_N_MIO-1:0]       mio_attr;
  pad_attr_t [`PINMUX_N_DIO-1:0]       dio_attr;
  logic      [`PINMUX_N_MIO-1:0]       mio_out;
  logic      [`PINMUX_N_MIO-1:0]       mio_oe;
  logic      [`PINMUX_N_MIO-1:0]       mio_in;

  // Select and attribute registers
  pinmux_regs u_regs (
    .clk_i,
    .arst_n_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_sel_i,
    .wb_dat_o,
    .wb_ack_o,
    .insel_o    ( insel    ),
    .outsel_o   ( outsel   ),
    .mio_attr_o ( mio_attr ),
    .dio_attr_o ( dio_attr )
  );

  // Peripheral to MIO routing
  pinmux_matrix u_matrix (
    .insel_i     ( insel   ),
    .outsel_i    ( outsel  ),
    .periph_out_i,
    .periph_oe_i,
    .periph_in_o,
    .mio_in_i    ( mio_in  ),
    .mio_out_o   ( mio_out ),
    .mio_oe_o    ( mio_oe  )
  );

  // DIO bypasses the matrix
  padring #(
    .N_DIO ( `PINMUX_N_DIO ),
    .N_MIO ( `PINMUX_N_MIO )
  ) u_padring (
    .dio_pad_io,
    .mio_pad_io,
    .dio_out_i,
    .dio_oe_i,
    .dio_attr_i   ( dio_attr ),
    .mio_out_i    ( mio_out  ),
    .mio_oe_i     ( mio_oe   ),
    .mio_attr_i   ( mio_attr ),
    .dio_in_o,
    .mio_in_o     ( mio_in   ),
    .dio_in_raw_o,
    .mio_in_raw_o
  );

endmodule : pinmux_top

//--- sources.f
+incdir+rtl
rtl/pinmux_pkg.sv
rtl/pad_wrapper.sv
rtl/padring.sv
rtl/pinmux_regs.sv
rtl/pinmux_matrix.sv
rtl/pinmux_top.sv
tb/tb_clkgen.sv
tb/pinmux_properties.sv
tb/pinmux_tb.sv

//--- tb/pinmux_properties.sv
`timescale 1ns/100ps

module pinmux_properties (
  input logic clk_i,
  input logic arst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Ack only answers a live request
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
      $error("ack raised without cyc and stb");
      fail_cnt++;
    end

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wb_ack_i |=> !wb_ack_i)
    else begin
      $error("ack held high for two cycles");
      fail_cnt++;
    end

  // Reset clears ack
  ack_low_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !wb_ack_i)
    else begin
      $error("ack high during reset");
      fail_cnt++;
    end

endmodule : pinmux_properties

//--- tb/pinmux_tb.sv
`timescale 1ns/100ps

`include "pinmux_macros.svh"

module pinmux_tb;

  localparam int NM = `PINMUX_N_MIO;
  localparam int ND = `PINMUX_N_DIO;
  localparam int NPI = `PINMUX_N_PERIPH_IN;
  localparam int NPO = `PINMUX_N_PERIPH_OUT;

  logic           clk;
  logic           arst_n;
  logic           wb_cyc;
  logic           wb_stb;
  logic           wb_we;
  logic [7:0]     wb_adr;
  logic [31:0]    wb_dat_w;
  logic [31:0]    wb_dat_r;
  logic [3:0]     wb_sel;
  logic           wb_ack;
  logic [NPO-1:0] periph_out;
  logic [NPO-1:0] periph_oe;
  logic [NPI-1:0] periph_in;
  logic [ND-1:0]  dio_out;
  logic [ND-1:0]  dio_oe;
  logic [ND-1:0]  dio_in;
  wire  [NM-1:0]  mio_pad;
  wire  [ND-1:0]  dio_pad;
  logic [NM-1:0]  mio_raw;
  logic [ND-1:0]  dio_raw;
  // Testbench side pad drivers
  logic [NM-1:0]  mio_drv_en;
  logic [NM-1:0]  mio_drv_val;
  logic [ND-1:0]  dio_drv_en;
  logic [ND-1:0]  dio_drv_val;

  logic [15:0]    lfsr;
  // Expected register contents with one entry per word address
  logic [31:0]    shadow [0:63];
  int             n_pass;
  int             n_fail;
  int             test_errs;

  tb_clkgen u_clkgen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  pinmux_top uut (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .wb_cyc_i     ( wb_cyc     ),
    .wb_stb_i     ( wb_stb     ),
    .wb_we_i      ( wb_we      ),
    .wb_adr_i     ( wb_adr     ),
    .wb_dat_i     ( wb_dat_w   ),
    .wb_sel_i     ( wb_sel     ),
    .wb_dat_o     ( wb_dat_r   ),
    .wb_ack_o     ( wb_ack     ),
    .periph_out_i ( periph_out ),
    .periph_oe_i  ( periph_oe  ),
    .periph_in_o  ( periph_in  ),
    .dio_out_i    ( dio_out    ),
    .dio_oe_i     ( dio_oe     ),
    .dio_in_o     ( dio_in     ),
    .mio_pad_io   ( mio_pad    ),
    .dio_pad_io   ( dio_pad    ),
    .mio_in_raw_o ( mio_raw    ),
    .dio_in_raw_o ( dio_raw    )
  );

  bind pinmux_top pinmux_properties u_props (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_ack_i ( wb_ack_o )
  );

  // Pads float unless the testbench enables its driver
  for (genvar j = 0; j < NM; j++) begin : gen_mio_drv
    assign mio_pad[j] = mio_drv_en[j] ? mio_drv_val[j] : 1'bz;
  end
  for (genvar j = 0; j < ND; j++) begin : gen_dio_drv
    assign dio_pad[j] = dio_drv_en[j] ? dio_drv_val[j] : 1'bz;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Field width of the register at a byte address or zero where unmapped
  function automatic logic [31:0] field_mask(input logic [7:0] adr);
    int idx;
    idx = int'(adr[5:2]);
    case (adr[7:6])
      2'd0: return (idx < NPI) ? 32'hF : 32'h0;
      2'd1: return (idx < NM) ? 32'hF : 32'h0;
      2'd2: return (idx < NM) ? 32'h3 : 32'h0;
      default: return (idx < ND) ? 32'h3 : 32'h0;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_mio(input string name, input logic [NM-1:0] exp, input logic [NM-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_periph(input string name, input logic [NPI-1:0] exp,
                              input logic [NPI-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_dio(input string name, input logic [ND-1:0] exp, input logic [ND-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  // One classic cycle with the request held until ack is seen
  task automatic wb_transfer(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
    int cnt;
    cnt = 0;
    rdat = '0;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    wb_sel = sel;
    // Ack is registered so look half a clock after each edge
    do begin
      @(negedge clk);
      cnt++;
    end while (!wb_ack && cnt < 20);
    if (wb_ack) begin
      rdat = wb_dat_r;
      // Ack belongs on the first edge after the request
      if (cnt != 1) begin
        $display("Wishbone ack came after %0d cycles instead of 1 at address %h", cnt, adr);
        test_errs++;
      end
    end else begin
      $display("No Wishbone ack within 20 cycles at address %h", adr);
      test_errs++;
    end
    // Keep the request up through the edge that drops ack
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  // Write and record what the register should now hold
  // Only byte lane 0 carries register bits
  task automatic wb_write_lanes(input logic [7:0] adr, input logic [31:0] dat,
                                input logic [3:0] sel);
    logic [31:0] unused;
    if (sel[0]) begin
      shadow[adr[7:2]] = dat & field_mask(adr);
    end
    wb_transfer(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    wb_write_lanes(adr, dat, 4'hF);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_transfer(1'b0, adr, 32'h0, 4'hF, dat);
  endtask

  // Walk the whole map including the gaps
  task automatic check_all_regs(input string name);
    logic [31:0] rd;
    for (int w = 0; w < 64; w++) begin
      wb_read(8'(w * 4), rd);
      check_word(name, shadow[w], rd);
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      n_pass++;
      $display("[PASS] %s", name);
    end else begin
      n_fail++;
      $display("[FAIL] %s with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic test_regs;
    for (int w = 0; w < 64; w++) begin
      if (field_mask(8'(w * 4)) != 32'h0) begin
        wb_write(8'(w * 4), rand_bits(32));
      end
    end
    // Low byte lane off leaves the register as it was
    wb_write_lanes(8'(`PINMUX_INSEL_BASE), ~shadow[0], 4'hE);
    check_all_regs("register readback");
    finish_test("register readback");
  endtask

  task automatic test_out_routing;
    logic [NM-1:0] exp;
    int src;
    // Pad j takes peripheral 3j+1 mod 8 so every source is used once
    for (int j = 0; j < NM; j++) begin
      wb_write(8'(`PINMUX_MIO_ATTR_BASE + 4 * j), 32'h0);
      wb_write(8'(`PINMUX_OUTSEL_BASE + 4 * j), 32'(2 + (3 * j + 1) % NPO));
    end
    for (int r = 0; r < 8; r++) begin
      @(negedge clk);
      periph_out = NPO'(rand_bits(NPO));
      periph_oe = NPO'(rand_bits(NPO));
      for (int j = 0; j < NM; j++) begin
        src = (3 * j + 1) % NPO;
        // A disabled source leaves the pad free for the opposite testbench value
        mio_drv_en[j] = ~periph_oe[src];
        mio_drv_val[j] = ~periph_out[src];
        exp[j] = periph_oe[src] ? periph_out[src] : ~periph_out[src];
      end
      #5;
      check_mio("output routing", exp, mio_pad);
    end
    @(negedge clk);
    mio_drv_en = '0;
    // Odd pads drive constant 1 and even pads constant 0
    for (int j = 0; j < NM; j++) begin
      wb_write(8'(`PINMUX_OUTSEL_BASE + 4 * j), 32'(j % 2));
      exp[j] = (j % 2 == 1);
    end
    @(negedge clk);
    #5;
    check_mio("output constants", exp, mio_pad);
    finish_test("output routing");
  endtask

  task automatic test_in_routing;
    logic [3:0]     sel [NPI];
    logic [NPI-1:0] exp;
    @(negedge clk);
    periph_oe = '0;
    // Pads route from disabled peripherals and the DUT releases them
    for (int j = 0; j < NM; j++) begin
      wb_write(8'(`PINMUX_OUTSEL_BASE + 4 * j), 32'(2 + j));
    end
    // Codes span the full range and out-of-range codes read as 0
    for (int k = 0; k < NPI; k++) begin
      sel[k] = 4'(rand_bits(4));
      wb_write(8'(`PINMUX_INSEL_BASE + 4 * k), 32'(sel[k]));
    end
    for (int r = 0; r < 8; r++) begin
      @(negedge clk);
      mio_drv_en = '1;
      mio_drv_val = NM'(rand_bits(NM));
      for (int k = 0; k < NPI; k++) begin
        if (int'(sel[k]) >= 2 && int'(sel[k]) < 2 + NM) begin
          exp[k] = mio_drv_val[int'(sel[k]) - 2];
        end else begin
          exp[k] = (sel[k] == 4'd1);
        end
      end
      #5;
      check_periph("input routing", exp, periph_in);
      check_mio("input raw", mio_drv_val, mio_raw);
    end
    @(negedge clk);
    mio_drv_en = '0;
    finish_test("input routing");
  endtask

  task automatic test_attrs;
    // Invert is bit 1 and open drain bit 0
    for (int j = 0; j < NM; j++) begin
      wb_write(8'(`PINMUX_MIO_ATTR_BASE + 4 * j), 32'h2);
      wb_write(8'(`PINMUX_OUTSEL_BASE + 4 * j), 32'(2 + j));
      wb_write(8'(`PINMUX_INSEL_BASE + 4 * j), 32'(2 + j));
    end
    @(negedge clk);
    periph_oe = '1;
    periph_out = NPO'(rand_bits(NPO));
    #5;
    check_mio("invert pad", ~periph_out, mio_pad);
    check_mio("invert raw", ~periph_out, mio_raw);
    check_periph("invert core", periph_out, periph_in);
    for (int j = 0; j < NM; j++) begin
      wb_write(8'(`PINMUX_MIO_ATTR_BASE + 4 * j), 32'h1);
    end
    @(negedge clk);
    periph_out = NPO'(rand_bits(NPO));
    // Released pads are pulled high by the testbench
    mio_drv_en = periph_out;
    mio_drv_val = '1;
    #5;
    check_mio("open drain pad", periph_out, mio_pad);
    check_periph("open drain core", periph_out, periph_in);
    // An outside low takes over every released pad
    @(negedge clk);
    mio_drv_val = '0;
    #5;
    check_mio("open drain release", '0, mio_pad);
    check_periph("open drain release core", '0, periph_in);
    @(negedge clk);
    mio_drv_en = '0;
    finish_test("pad attributes");
  endtask

  task automatic test_dio;
    // Pad 0 inverts and pad 1 is plain push-pull
    wb_write(8'(`PINMUX_DIO_ATTR_BASE), 32'h2);
    wb_write(8'(`PINMUX_DIO_ATTR_BASE + 4), 32'h0);
    for (int r = 0; r < 4; r++) begin
      @(negedge clk);
      dio_drv_en = '0;
      dio_oe = '1;
      dio_out = ND'(rand_bits(ND));
      #5;
      check_dio("dio pad", dio_out ^ ND'(1), dio_pad);
      check_dio("dio core out", dio_out, dio_in);
      @(negedge clk);
      dio_oe = '0;
      dio_drv_en = '1;
      dio_drv_val = ND'(rand_bits(ND));
      #5;
      check_dio("dio raw", dio_drv_val, dio_raw);
      check_dio("dio core in", dio_drv_val ^ ND'(1), dio_in);
    end
    @(negedge clk);
    dio_drv_en = '0;
    finish_test("dedicated pads");
  endtask

  task automatic test_unmapped;
    logic [31:0] rd;
    wb_read(8'hC8, rd);
    check_word("unmapped read", 32'h0, rd);
    wb_read(8'hFC, rd);
    check_word("unmapped read", 32'h0, rd);
    wb_write(8'hC8, rand_bits(32));
    wb_write(8'hFC, 32'hFFFF_FFFF);
    check_all_regs("unmapped write");
    finish_test("unmapped access");
  endtask

  initial begin
    int cnt;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    periph_out = '0;
    periph_oe = '0;
    dio_out = '0;
    dio_oe = '0;
    mio_drv_en = '0;
    mio_drv_val = '0;
    dio_drv_en = '0;
    dio_drv_val = '0;
    lfsr = 16'd83;
    n_pass = 0;
    n_fail = 0;
    test_errs = 0;
    for (int w = 0; w < 64; w++) begin
      shadow[w] = '0;
    end
    cnt = 0;
    while (arst_n !== 1'b1 && cnt < 20) begin
      @(negedge clk);
      cnt++;
    end
    if (arst_n !== 1'b1) begin
      $display("Reset was never released");
      test_errs++;
    end
    // Cleared registers leave every pad driving 0
    #5;
    check_mio("reset pads", '0, mio_pad);
    check_all_regs("reset values");
    finish_test("reset values");
    test_regs();
    test_out_routing();
    test_in_routing();
    test_attrs();
    test_dio();
    test_unmapped();
    $display("tests passed %0d failed %0d assertion failures %0d",
             n_pass, n_fail, uut.u_props.fail_cnt);
    if (n_fail == 0 && uut.u_props.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : pinmux_tb

//--- tb/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int PERIOD_NS = 20,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  // Free-running clock, stopped only by the end of the run
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held over a fixed count of rising edges, released on a falling one
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule : tb_clkgen
